/* sources.f */
src/zb_regmap_pkg.sv
src/zb_addr_pkg.sv
src/host_reg_fsm.sv
src/bridge_regs.sv
src/event_counters.sv
src/mem_profiler.sv
src/addr_xlate.sv
src/zynq_bridge_top.sv
verification/zynq_bridge_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
   --top-module zynq_bridge_tb -Mdir obj_dir -o zynq_bridge_sim

output="$(./obj_dir/zynq_bridge_sim)"
echo "$output"

if echo "$output" | grep -qx "test passed"; then
   exit 0
else
   exit 1
fi

/* verification/zynq_bridge_tb.sv */
`timescale 1ns/1ps

module zynq_bridge_tb;

   import zb_regmap_pkg::*;
   import zb_addr_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int QUARTER      = CLK_PERIOD / 4;
   localparam int RESET_CYCLES = 8;
   localparam int WAIT_LIMIT   = 16;
   localparam int HOLD_CYCLES  = 3;
   localparam int MAX_ENTRIES  = 64;
   localparam int N_DRAM       = 8;
   localparam int N_STALL      = 2;

   localparam int OP_WRITE      = 0;
   localparam int OP_READ       = 1;
   localparam int OP_HOST       = 2;
   localparam int OP_DRAM       = 3;
   localparam int OP_IDLE       = 4;
   localparam int OP_CORE_RST   = 5;
   localparam int OP_MCYCLE     = 6;
   localparam int OP_DRAM_STALL = 7;

   logic                   clk_i = 1'b0;
   logic                   arst_n_i;
   logic [REG_ADDR_W-1:0]  reg_awaddr_i;
   logic [REG_ADDR_W-1:0]  reg_araddr_i;
   logic [REG_DATA_W-1:0]  reg_wdata_i;
   logic                   reg_awvalid_i;
   logic                   reg_wvalid_i;
   logic                   reg_arvalid_i;
   logic                   reg_bready_i;
   logic                   reg_rready_i;
   logic                   reg_awready_o;
   logic                   reg_wready_o;
   logic                   reg_arready_o;
   logic                   reg_bvalid_o;
   logic                   reg_rvalid_o;
   logic [1:0]             reg_bresp_o;
   logic [1:0]             reg_rresp_o;
   logic [REG_DATA_W-1:0]  reg_rdata_o;
   logic                   core_reset_o;
   logic [HOST_ADDR_W-1:0] host_awaddr_i;
   logic [HOST_ADDR_W-1:0] host_araddr_i;
   logic [CORE_ADDR_W-1:0] core_awaddr_o;
   logic [CORE_ADDR_W-1:0] core_araddr_o;
   logic [CORE_ADDR_W-1:0] core_dram_awaddr_i;
   logic [CORE_ADDR_W-1:0] core_dram_araddr_i;
   logic                   core_dram_awvalid_i;
   logic                   core_dram_arvalid_i;
   logic                   dram_awready_i;
   logic                   dram_arready_i;
   logic [CORE_ADDR_W-1:0] dram_awaddr_o;
   logic [CORE_ADDR_W-1:0] dram_araddr_o;

   // stimulus table, one row per operation
   int          op_tab   [MAX_ENTRIES];
   logic [31:0] addr_tab [MAX_ENTRIES];
   logic [31:0] data_tab [MAX_ENTRIES];
   logic [31:0] exp_tab  [MAX_ENTRIES];
   logic [1:0]  resp_tab [MAX_ENTRIES];

   int          n_entries = 0;
   bit          table_built = 1'b0;
   int          err_count = 0;
   int          n_checks = 0;
   logic [31:0] dram_base_exp;
   logic [31:0] mcycle_prev = 32'd0;

   zynq_bridge_top zynq_bridge_top_inst (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // window 0 maps onto core DRAM at 0x8000_0000, window 1 onto the local space at 0
   function automatic logic [31:0] host_expected(input logic [HOST_ADDR_W-1:0] a);
      logic [31:0] base;
      base = a[HOST_WINDOW_BIT] ? 32'h0000_0000 : 32'h8000_0000;
      return base | (32'(a) & 32'h0FFF_FFFF);
   endfunction

   // flipping bit 31 strips the core DRAM base, then the host buffer is added
   function automatic logic [31:0] rebase_expected(input logic [31:0] a, input logic [31:0] b);
      return {~a[31], a[30:0]} + b;
   endfunction

   function automatic string op_name(input int op);
      case (op)
         OP_WRITE:      return "write";
         OP_READ:       return "read";
         OP_HOST:       return "host xlate";
         OP_DRAM:       return "dram request";
         OP_DRAM_STALL: return "stalled dram request";
         OP_IDLE:       return "idle";
         OP_CORE_RST:   return "core reset";
         default:       return "mcycle";
      endcase
   endfunction

   task automatic add_entry(input int op, input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] expv, input logic [1:0] resp);
      op_tab[n_entries]   = op;
      addr_tab[n_entries] = addr;
      data_tab[n_entries] = data;
      exp_tab[n_entries]  = expv;
      resp_tab[n_entries] = resp;
      n_entries++;
   endtask

   task automatic add_write(input logic [REG_ADDR_W-1:0] a, input logic [31:0] d,
                            input logic [1:0] r);
      add_entry(OP_WRITE, 32'(a), d, 32'd0, r);
   endtask

   task automatic add_read(input logic [REG_ADDR_W-1:0] a, input logic [31:0] e,
                           input logic [1:0] r);
      add_entry(OP_READ, 32'(a), 32'd0, e, r);
   endtask

   task automatic add_host(input logic [HOST_ADDR_W-1:0] aw, input logic [HOST_ADDR_W-1:0] ar);
      add_entry(OP_HOST, 32'(aw), 32'(ar), host_expected(aw), RESP_OKAY);
   endtask

   task automatic build_table();
      logic [31:0]             rng;
      logic [31:0]             aw;
      logic [31:0]             ar;
      logic [PROF_REGIONS-1:0] prof_exp;
      int                      w;
      rng = 32'd64939;
      prof_exp = '0;
      // everything reads zero straight out of reset
      add_read(REG_CTRL, 32'd0, RESP_OKAY);
      for (w = 0; w < 4; w++)
         add_read(REG_PROF0 + 9'(4 * w), 32'd0, RESP_OKAY);
      add_read(REG_MCYCLE_LO, 32'd0, RESP_OKAY);
      add_read(REG_MCYCLE_HI, 32'd0, RESP_OKAY);
      add_read(REG_DRAM_WR_CNT, 32'd0, RESP_OKAY);
      add_read(REG_DRAM_RD_CNT, 32'd0, RESP_OKAY);
      add_entry(OP_CORE_RST, 32'd0, 32'd0, 32'd1, RESP_OKAY);
      rng = xorshift32(rng);
      dram_base_exp = rng & 32'hFFFF_F000;
      add_write(REG_DRAM_VALID, 32'd1, RESP_OKAY);
      add_read(REG_DRAM_VALID, 32'd1, RESP_OKAY);
      add_write(REG_DRAM_BASE, dram_base_exp, RESP_OKAY);
      add_read(REG_DRAM_BASE, dram_base_exp, RESP_OKAY);
      // read-only and unmapped targets
      add_write(REG_PROF0, 32'hFFFF_FFFF, RESP_SLVERR);
      add_read(REG_PROF0, 32'd0, RESP_OKAY);
      add_write(REG_MCYCLE_LO, 32'hFFFF_FFFF, RESP_SLVERR);
      add_read(REG_MCYCLE_LO, 32'd0, RESP_OKAY);
      add_write(9'h100, 32'h1234_5678, RESP_SLVERR);
      add_read(9'h100, 32'd0, RESP_SLVERR);
      add_read(REG_CTRL, 32'd0, RESP_OKAY);
      add_read(REG_DRAM_VALID, 32'd1, RESP_OKAY);
      add_read(REG_DRAM_BASE, dram_base_exp, RESP_OKAY);
      add_host(30'h0000_1234, 30'h2ABC_DEF0);
      add_host(30'h3FFF_FFFF, 30'h1FFF_FFFF);
      for (w = 0; w < 2; w++)
      begin
         rng = xorshift32(rng);
         aw = rng;
         rng = xorshift32(rng);
         add_host(aw[HOST_ADDR_W-1:0], rng[HOST_ADDR_W-1:0]);
      end
      // release the core and generate DRAM traffic, the last requests are never accepted
      add_write(REG_CTRL, 32'd1, RESP_OKAY);
      add_entry(OP_CORE_RST, 32'd0, 32'd0, 32'd0, RESP_OKAY);
      add_read(REG_CTRL, 32'd1, RESP_OKAY);
      for (w = 0; w < N_DRAM + N_STALL; w++)
      begin
         rng = xorshift32(rng);
         aw = rng | DRAM_BASE_XOR;
         rng = xorshift32(rng);
         ar = rng | DRAM_BASE_XOR;
         prof_exp[aw[PROF_REGION_LSB +: 7]] = 1'b1;
         prof_exp[ar[PROF_REGION_LSB +: 7]] = 1'b1;
         add_entry((w < N_DRAM) ? OP_DRAM : OP_DRAM_STALL, aw, ar,
                   rebase_expected(aw, dram_base_exp), RESP_OKAY);
      end
      add_entry(OP_IDLE, 32'd0, 32'd2, 32'd0, RESP_OKAY);
      add_read(REG_DRAM_WR_CNT, 32'(N_DRAM), RESP_OKAY);
      add_read(REG_DRAM_RD_CNT, 32'(N_DRAM), RESP_OKAY);
      for (w = 0; w < 4; w++)
         add_read(REG_PROF0 + 9'(4 * w), prof_exp[32 * w +: 32], RESP_OKAY);
      add_entry(OP_MCYCLE, 32'(REG_MCYCLE_LO), 32'd0, 32'd0, RESP_OKAY);
      add_entry(OP_IDLE, 32'd0, 32'd3, 32'd0, RESP_OKAY);
      add_entry(OP_MCYCLE, 32'(REG_MCYCLE_LO), 32'd0, 32'd0, RESP_OKAY);
      // putting the core back in reset clears the statistics but not the base
      add_write(REG_CTRL, 32'd0, RESP_OKAY);
      add_entry(OP_CORE_RST, 32'd0, 32'd0, 32'd1, RESP_OKAY);
      for (w = 0; w < 4; w++)
         add_read(REG_PROF0 + 9'(4 * w), 32'd0, RESP_OKAY);
      add_read(REG_DRAM_WR_CNT, 32'd0, RESP_OKAY);
      add_read(REG_DRAM_RD_CNT, 32'd0, RESP_OKAY);
      add_read(REG_MCYCLE_LO, 32'd0, RESP_OKAY);
      add_read(REG_DRAM_BASE, dram_base_exp, RESP_OKAY);
      table_built = 1'b1;
   endtask

   task automatic compare_value(input string name, input logic [31:0] expv,
                                input logic [31:0] got);
      n_checks++;
      if (got !== expv)
      begin
         $display("FAIL %s expected 0x%h got 0x%h", name, expv, got);
         err_count++;
      end
   endtask

   // starts and ends just after a falling edge, holds the response ready low a while
   task automatic reg_access(input bit is_write, input logic [REG_ADDR_W-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic [1:0] resp);
      int n;
      bit seen;
      bit valid_now;
      rdata = '0;
      resp = '0;
      if (is_write)
      begin
         reg_awaddr_i  = addr;
         reg_wdata_i   = wdata;
         reg_awvalid_i = 1'b1;
         reg_wvalid_i  = 1'b1;
      end
      else
      begin
         reg_araddr_i  = addr;
         reg_arvalid_i = 1'b1;
      end
      n = 0;
      seen = 1'b0;
      while (!seen && n < WAIT_LIMIT)
      begin
         #(QUARTER);
         seen = is_write ? (reg_awready_o && reg_wready_o) : reg_arready_o;
         @(negedge clk_i);
         n++;
      end
      reg_awvalid_i = 1'b0;
      reg_wvalid_i  = 1'b0;
      reg_arvalid_i = 1'b0;
      if (!seen)
      begin
         $display("ERROR request to 0x%h was never accepted", addr);
         err_count++;
         return;
      end
      #(QUARTER);
      n = 0;
      while (!(is_write ? reg_bvalid_o : reg_rvalid_o) && n < WAIT_LIMIT)
      begin
         @(negedge clk_i);
         #(QUARTER);
         n++;
      end
      if (!(is_write ? reg_bvalid_o : reg_rvalid_o))
      begin
         $display("ERROR no response arrived for the access to 0x%h", addr);
         err_count++;
         @(negedge clk_i);
         return;
      end
      rdata = reg_rdata_o;
      resp = is_write ? reg_bresp_o : reg_rresp_o;
      repeat (HOLD_CYCLES)
      begin
         @(negedge clk_i);
         #(QUARTER);
         valid_now = is_write ? reg_bvalid_o : reg_rvalid_o;
         if (!valid_now || (is_write ? reg_bresp_o : reg_rresp_o) != resp ||
             (!is_write && reg_rdata_o != rdata))
         begin
            $display("ERROR response for 0x%h changed while ready was held low", addr);
            err_count++;
         end
      end
      @(negedge clk_i);
      reg_bready_i = is_write;
      reg_rready_i = !is_write;
      @(negedge clk_i);
      reg_bready_i = 1'b0;
      reg_rready_i = 1'b0;
   endtask

   initial
   begin
      wait (table_built);
      repeat (n_entries * 30 + 100) @(posedge clk_i);
      $display("ERROR watchdog expired before the table was finished");
      $display("test failed");
      $finish;
   end

   initial
   begin
      int          i;
      int          errs_before;
      logic [31:0] rdata;
      logic [1:0]  resp;
      arst_n_i = 1'b0;
      reg_awaddr_i = '0;
      reg_araddr_i = '0;
      reg_wdata_i = '0;
      reg_awvalid_i = 1'b0;
      reg_wvalid_i = 1'b0;
      reg_arvalid_i = 1'b0;
      reg_bready_i = 1'b0;
      reg_rready_i = 1'b0;
      host_awaddr_i = '0;
      host_araddr_i = '0;
      core_dram_awaddr_i = '0;
      core_dram_araddr_i = '0;
      core_dram_awvalid_i = 1'b0;
      core_dram_arvalid_i = 1'b0;
      dram_awready_i = 1'b0;
      dram_arready_i = 1'b0;
      build_table();
      repeat (RESET_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;
      #(QUARTER);
      compare_value("core_reset_o", 32'd1, 32'(core_reset_o));
      compare_value("reg_bvalid_o", 32'd0, 32'(reg_bvalid_o));
      compare_value("reg_rvalid_o", 32'd0, 32'(reg_rvalid_o));
      compare_value("reg_awready_o", 32'd0, 32'(reg_awready_o));
      compare_value("reg_wready_o", 32'd0, 32'(reg_wready_o));
      compare_value("reg_arready_o", 32'd0, 32'(reg_arready_o));
      $display("reset state: %s", (err_count == 0) ? "ok" : "errors");
      @(negedge clk_i);
      for (i = 0; i < n_entries; i++)
      begin
         errs_before = err_count;
         case (op_tab[i])
            OP_WRITE:
            begin
               reg_access(1'b1, addr_tab[i][8:0], data_tab[i], rdata, resp);
               compare_value("reg_bresp_o", 32'(resp_tab[i]), 32'(resp));
            end
            OP_READ:
            begin
               reg_access(1'b0, addr_tab[i][8:0], 32'd0, rdata, resp);
               compare_value("reg_rdata_o", exp_tab[i], rdata);
               compare_value("reg_rresp_o", 32'(resp_tab[i]), 32'(resp));
            end
            OP_HOST:
            begin
               host_awaddr_i = addr_tab[i][HOST_ADDR_W-1:0];
               host_araddr_i = data_tab[i][HOST_ADDR_W-1:0];
               #(QUARTER);
               compare_value("core_awaddr_o", exp_tab[i], core_awaddr_o);
               compare_value("core_araddr_o", host_expected(data_tab[i][HOST_ADDR_W-1:0]),
                             core_araddr_o);
               @(negedge clk_i);
            end
            OP_DRAM, OP_DRAM_STALL:
            begin
               core_dram_awaddr_i = addr_tab[i];
               core_dram_araddr_i = data_tab[i];
               core_dram_awvalid_i = 1'b1;
               core_dram_arvalid_i = 1'b1;
               dram_awready_i = (op_tab[i] == OP_DRAM);
               dram_arready_i = (op_tab[i] == OP_DRAM);
               #(QUARTER);
               compare_value("dram_awaddr_o", exp_tab[i], dram_awaddr_o);
               compare_value("dram_araddr_o", rebase_expected(data_tab[i], dram_base_exp),
                             dram_araddr_o);
               @(negedge clk_i);
               core_dram_awvalid_i = 1'b0;
               core_dram_arvalid_i = 1'b0;
               dram_awready_i = 1'b0;
               dram_arready_i = 1'b0;
            end
            OP_IDLE:
               repeat (data_tab[i]) @(negedge clk_i);
            OP_CORE_RST:
            begin
               #(QUARTER);
               compare_value("core_reset_o", exp_tab[i], 32'(core_reset_o));
               @(negedge clk_i);
            end
            default:
            begin
               reg_access(1'b0, addr_tab[i][8:0], 32'd0, rdata, resp);
               compare_value("reg_rresp_o", 32'(RESP_OKAY), 32'(resp));
               n_checks++;
               if (rdata <= mcycle_prev)
               begin
                  $display("FAIL reg_rdata_o expected above 0x%h got 0x%h", mcycle_prev, rdata);
                  err_count++;
               end
               mcycle_prev = rdata;
            end
         endcase
         $display("entry %0d %s at 0x%h: %s", i, op_name(op_tab[i]), addr_tab[i],
                  (err_count == errs_before) ? "ok" : "errors");
      end
      $display("%0d entries, %0d checks, %0d errors", n_entries, n_checks, err_count);
      if (err_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

/* src/zynq_bridge_top.sv */
`timescale 1ns/1ps

module zynq_bridge_top
  (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  logic [zb_regmap_pkg::REG_ADDR_W-1:0] reg_awaddr_i,
   input  logic [zb_regmap_pkg::REG_ADDR_W-1:0] reg_araddr_i,
   input  logic [zb_regmap_pkg::REG_DATA_W-1:0] reg_wdata_i,
   input  logic                                 reg_awvalid_i,
   input  logic                                 reg_wvalid_i,
   input  logic                                 reg_arvalid_i,
   input  logic                                 reg_bready_i,
   input  logic                                 reg_rready_i,
   output logic                                 reg_awready_o,
   output logic                                 reg_wready_o,
   output logic                                 reg_arready_o,
   output logic                                 reg_bvalid_o,
   output logic                                 reg_rvalid_o,
   output logic [1:0]                           reg_bresp_o,
   output logic [1:0]                           reg_rresp_o,
   output logic [zb_regmap_pkg::REG_DATA_W-1:0] reg_rdata_o,
   output logic                                 core_reset_o,
   input  logic [zb_addr_pkg::HOST_ADDR_W-1:0]  host_awaddr_i,
   input  logic [zb_addr_pkg::HOST_ADDR_W-1:0]  host_araddr_i,
   output logic [zb_addr_pkg::CORE_ADDR_W-1:0]  core_awaddr_o,
   output logic [zb_addr_pkg::CORE_ADDR_W-1:0]  core_araddr_o,
   input  zb_addr_pkg::dram_addr_u              core_dram_awaddr_i,
   input  zb_addr_pkg::dram_addr_u              core_dram_araddr_i,
   input  logic                                 core_dram_awvalid_i,
   input  logic                                 core_dram_arvalid_i,
   input  logic                                 dram_awready_i,
   input  logic                                 dram_arready_i,
   output logic [zb_addr_pkg::CORE_ADDR_W-1:0]  dram_awaddr_o,
   output logic [zb_addr_pkg::CORE_ADDR_W-1:0]  dram_araddr_o
  );

   import zb_regmap_pkg::*;
   import zb_addr_pkg::*;

   logic                    wr_en;
   logic [REG_ADDR_W-1:0]   reg_addr;
   logic [REG_DATA_W-1:0]   reg_wdata;
   logic [REG_DATA_W-1:0]   rd_data;
   logic                    rd_err;
   logic                    wr_err;
   logic                    run;
   logic [CORE_ADDR_W-1:0]  dram_base;
   logic [PROF_REGIONS-1:0] prof_map;
   logic [63:0]             mcycle;
   logic [31:0]             dram_wr_cnt;
   logic [31:0]             dram_rd_cnt;

   host_reg_fsm host_reg_fsm_inst
     (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .reg_awaddr_i  (reg_awaddr_i),
      .reg_araddr_i  (reg_araddr_i),
      .reg_wdata_i   (reg_wdata_i),
      .reg_awvalid_i (reg_awvalid_i),
      .reg_wvalid_i  (reg_wvalid_i),
      .reg_arvalid_i (reg_arvalid_i),
      .reg_bready_i  (reg_bready_i),
      .reg_rready_i  (reg_rready_i),
      .reg_awready_o (reg_awready_o),
      .reg_wready_o  (reg_wready_o),
      .reg_arready_o (reg_arready_o),
      .reg_bvalid_o  (reg_bvalid_o),
      .reg_rvalid_o  (reg_rvalid_o),
      .reg_bresp_o   (reg_bresp_o),
      .reg_rresp_o   (reg_rresp_o),
      .reg_rdata_o   (reg_rdata_o),
      .wr_en_o       (wr_en),
      .addr_o        (reg_addr),
      .wdata_o       (reg_wdata),
      .rd_data_i     (rd_data),
      .rd_err_i      (rd_err),
      .wr_err_i      (wr_err)
     );

   bridge_regs bridge_regs_inst
     (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .wr_en_i       (wr_en),
      .addr_i        (reg_addr),
      .wdata_i       (reg_wdata),
      .rd_data_o     (rd_data),
      .rd_err_o      (rd_err),
      .wr_err_o      (wr_err),
      .run_o         (run),
      .dram_base_o   (dram_base),
      .prof_map_i    (prof_map),
      .mcycle_i      (mcycle),
      .dram_wr_cnt_i (dram_wr_cnt),
      .dram_rd_cnt_i (dram_rd_cnt)
     );

   event_counters event_counters_inst
     (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .run_i          (run),
      .dram_awvalid_i (core_dram_awvalid_i),
      .dram_awready_i (dram_awready_i),
      .dram_arvalid_i (core_dram_arvalid_i),
      .dram_arready_i (dram_arready_i),
      .mcycle_o       (mcycle),
      .dram_wr_cnt_o  (dram_wr_cnt),
      .dram_rd_cnt_o  (dram_rd_cnt)
     );

   mem_profiler mem_profiler_inst
     (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .run_i      (run),
      .awvalid_i  (core_dram_awvalid_i),
      .arvalid_i  (core_dram_arvalid_i),
      .awaddr_i   (core_dram_awaddr_i),
      .araddr_i   (core_dram_araddr_i),
      .prof_map_o (prof_map)
     );

   addr_xlate addr_xlate_inst
     (
      .host_awaddr_i      (host_awaddr_i),
      .host_araddr_i      (host_araddr_i),
      .core_awaddr_o      (core_awaddr_o),
      .core_araddr_o      (core_araddr_o),
      .dram_base_i        (dram_base),
      .core_dram_awaddr_i (core_dram_awaddr_i),
      .core_dram_araddr_i (core_dram_araddr_i),
      .dram_awaddr_o      (dram_awaddr_o),
      .dram_araddr_o      (dram_araddr_o)
     )
;

   // the core stays in reset until the host sets the run bit
   assign core_reset_o = ~run;

endmodule

/* src/addr_xlate.sv */
`timescale 1ns/1ps

module addr_xlate
  (
   input  logic [zb_addr_pkg::HOST_ADDR_W-1:0] host_awaddr_i,
   input  logic [zb_addr_pkg::HOST_ADDR_W-1:0] host_araddr_i,
   output logic [zb_addr_pkg::CORE_ADDR_W-1:0] core_awaddr_o,
   output logic [zb_addr_pkg::CORE_ADDR_W-1:0] core_araddr_o,
   input  logic [zb_addr_pkg::CORE_ADDR_W-1:0] dram_base_i,
   input  zb_addr_pkg::dram_addr_u             core_dram_awaddr_i,
   input  zb_addr_pkg::dram_addr_u             core_dram_araddr_i,
   output logic [zb_addr_pkg::CORE_ADDR_W-1:0] dram_awaddr_o,
   output logic [zb_addr_pkg::CORE_ADDR_W-1:0] dram_araddr_o
  );

   import zb_addr_pkg::*;

   // window 0 lands in core DRAM at 0x8000_0000, window 1 in the local space at 0
   function automatic logic [CORE_ADDR_W-1:0] host_to_core(input logic [HOST_ADDR_W-1:0] a);
      host_to_core = {~a[HOST_WINDOW_BIT], 3'b000, a[HOST_OFFSET_W-1:0]};
   endfunction

   // strip the core DRAM base and move onto the buffer the host allocated
   function automatic logic [CORE_ADDR_W-1:0] rebase(input dram_addr_u a,
                                                     input logic [CORE_ADDR_W-1:0] base);
      rebase = (a.raw ^ DRAM_BASE_XOR) + base;
   endfunction

   assign core_awaddr_o = host_to_core(host_awaddr_i);
   assign core_araddr_o = host_to_core(host_araddr_i);

   assign dram_awaddr_o = rebase(core_dram_awaddr_i, dram_base_i);
   assign dram_araddr_o = rebase(core_dram_araddr_i, dram_base_i);

endmodule

/* src/mem_profiler.sv */
`timescale 1ns/1ps

module mem_profiler
  (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  logic                                 run_i,
   input  logic                                 awvalid_i,
   input  logic                                 arvalid_i,
   input  zb_addr_pkg::dram_addr_u              awaddr_i,
   input  zb_addr_pkg::dram_addr_u              araddr_i,
   output logic [zb_addr_pkg::PROF_REGIONS-1:0] prof_map_o
  );

   import zb_addr_pkg::*;

   logic [PROF_REGIONS-1:0] aw_hit;
   logic [PROF_REGIONS-1:0] ar_hit;
   logic [PROF_REGIONS-1:0] prof_map_q;

   // one-hot of the region each request falls in, ready is not required
   always_comb
   begin
      aw_hit = '0;
      ar_hit = '0;
      aw_hit[awaddr_i.fields.region] = awvalid_i;
      ar_hit[araddr_i.fields.region] = arvalid_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         prof_map_q <= '0;
      else if (!run_i)
         prof_map_q <= '0;
      else
         prof_map_q <= prof_map_q | aw_hit | ar_hit;
   end

   assign prof_map_o = prof_map_q;

endmodule

/* src/event_counters.sv */
`timescale 1ns/1ps

module event_counters
  (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic        run_i,
   input  logic        dram_awvalid_i,
   input  logic        dram_awready_i,
   input  logic        dram_arvalid_i,
   input  logic        dram_arready_i,
   output logic [63:0] mcycle_o,
   output logic [31:0] dram_wr_cnt_o,
   output logic [31:0] dram_rd_cnt_o
  );

   logic [63:0] mcycle_q;
   logic [31:0] wr_cnt_q;
   logic [31:0] rd_cnt_q;

   // only handshakes that complete are counted
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         mcycle_q <= '0;
         wr_cnt_q <= '0;
         rd_cnt_q <= '0;
      end
      else if (!run_i)
      begin
         // the core is held in reset so every count starts over
         mcycle_q <= '0;
         wr_cnt_q <= '0;
         rd_cnt_q <= '0;
      end
      else
      begin
         mcycle_q <= mcycle_q + 64'd1;
         if (dram_awvalid_i && dram_awready_i)
            wr_cnt_q <= wr_cnt_q + 32'd1;
         if (dram_arvalid_i && dram_arready_i)
            rd_cnt_q <= rd_cnt_q + 32'd1;
      end
   end

   assign mcycle_o      = mcycle_q;
   assign dram_wr_cnt_o = wr_cnt_q;
   assign dram_rd_cnt_o = rd_cnt_q;

endmodule

/* src/bridge_regs.sv */
`timescale 1ns/1ps

module bridge_regs
  (
   input  logic                                  clk_i,
   input  logic                                  arst_n_i,
   input  logic                                  wr_en_i,
   input  logic [zb_regmap_pkg::REG_ADDR_W-1:0]  addr_i,
   input  logic [zb_regmap_pkg::REG_DATA_W-1:0]  wdata_i,
   output logic [zb_regmap_pkg::REG_DATA_W-1:0]  rd_data_o,
   output logic                                  rd_err_o,
   output logic                                  wr_err_o,
   output logic                                  run_o,
   output logic [zb_addr_pkg::CORE_ADDR_W-1:0]   dram_base_o,
   input  logic [zb_addr_pkg::PROF_REGIONS-1:0]  prof_map_i,
   input  logic [63:0]                           mcycle_i,
   input  logic [31:0]                           dram_wr_cnt_i,
   input  logic [31:0]                           dram_rd_cnt_i
  );

   import zb_regmap_pkg::*;
   import zb_addr_pkg::*;

   logic [REG_DATA_W-1:0]  ctrl_q;
   logic [REG_DATA_W-1:0]  dram_valid_q;
   logic [CORE_ADDR_W-1:0] dram_base_q;

   // writes only land on the three host owned registers
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ctrl_q       <= '0;
         dram_valid_q <= '0;
         dram_base_q  <= '0;
      end
      else if (wr_en_i)
      begin
         case (addr_i)
            REG_CTRL:       ctrl_q       <= wdata_i;
            REG_DRAM_VALID: dram_valid_q <= wdata_i;
            REG_DRAM_BASE:  dram_base_q  <= wdata_i;
            default:        ;
         endcase
      end
   end

   // read data and both error flags come from the same decode
   always_comb
   begin
      rd_data_o = '0;
      rd_err_o  = 1'b0;
      wr_err_o  = 1'b1;
      case (addr_i)
         REG_CTRL:
         begin
            rd_data_o = ctrl_q;
            wr_err_o  = 1'b0;
         end
         REG_DRAM_VALID:
         begin
            rd_data_o = dram_valid_q;
            wr_err_o  = 1'b0;
         end
         REG_DRAM_BASE:
         begin
            rd_data_o = dram_base_q;
            wr_err_o  = 1'b0;
         end
         REG_PROF0:       rd_data_o = prof_map_i[0  +: 32];
         REG_PROF1:       rd_data_o = prof_map_i[32 +: 32];
         REG_PROF2:       rd_data_o = prof_map_i[64 +: 32];
         REG_PROF3:       rd_data_o = prof_map_i[96 +: 32];
         REG_MCYCLE_LO:   rd_data_o = mcycle_i[31:0];
         REG_MCYCLE_HI:   rd_data_o = mcycle_i[63:32];
         REG_DRAM_WR_CNT: rd_data_o = dram_wr_cnt_i;
         REG_DRAM_RD_CNT: rd_data_o = dram_rd_cnt_i;
         default:
            rd_err_o = 1'b1;
      endcase
   end

   // bit 0 of the control word releases the core from reset
   assign run_o       = ctrl_q[0];
   assign dram_base_o = dram_base_q;

endmodule

/* src/host_reg_fsm.sv */
`timescale 1ns/1ps

module host_reg_fsm
  (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic [zb_regmap_pkg::REG_ADDR_W-1:0] reg_awaddr_i,
   input  logic [zb_regmap_pkg::REG_ADDR_W-1:0] reg_araddr_i,
   input  logic [zb_regmap_pkg::REG_DATA_W-1:0] reg_wdata_i,
   input  logic                             reg_awvalid_i,
   input  logic                             reg_wvalid_i,
   input  logic                             reg_arvalid_i,
   input  logic                             reg_bready_i,
   input  logic                             reg_rready_i,
   output logic                             reg_awready_o,
   output logic                             reg_wready_o,
   output logic                             reg_arready_o,
   output logic                             reg_bvalid_o,
   output logic                             reg_rvalid_o,
   output logic [1:0]                       reg_bresp_o,
   output logic [1:0]                       reg_rresp_o,
   output logic [zb_regmap_pkg::REG_DATA_W-1:0] reg_rdata_o,
   output logic                             wr_en_o,
   output logic [zb_regmap_pkg::REG_ADDR_W-1:0] addr_o,
   output logic [zb_regmap_pkg::REG_DATA_W-1:0] wdata_o,
   input  logic [zb_regmap_pkg::REG_DATA_W-1:0] rd_data_i,
   input  logic                             rd_err_i,
   input  logic                             wr_err_i
  );

   import zb_regmap_pkg::*;

   localparam logic [1:0] IDLE       = 2'd0;
   localparam logic [1:0] WRITE_RESP = 2'd1;
   localparam logic [1:0] READ_RESP  = 2'd2;

   logic [1:0]            state_q;
   logic [1:0]            state_d;
   logic                  wr_req;
   logic                  rd_req;
   logic [REG_DATA_W-1:0] rdata_q;
   logic [1:0]            bresp_q;
   logic [1:0]            rresp_q;

   // a write needs both address and data, and beats a read in the same cycle
   assign wr_req = (state_q == IDLE) && reg_awvalid_i && reg_wvalid_i;
   assign rd_req = (state_q == IDLE) && reg_arvalid_i && !wr_req;

   assign reg_awready_o = wr_req;
   assign reg_wready_o  = wr_req;
   assign reg_arready_o = rd_req;

   // the decoder sees the accepted address in the same cycle
   assign wr_en_o = wr_req;
   assign addr_o  = wr_req ? reg_awaddr_i : reg_araddr_i;
   assign wdata_o = reg_wdata_i;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (wr_req)
               state_d = WRITE_RESP;
            else if (rd_req)
               state_d = READ_RESP;
         end
         WRITE_RESP:
         begin
            if (reg_bready_i)
               state_d = IDLE;
         end
         READ_RESP:
         begin
            if (reg_rready_i)
               state_d = IDLE;
         end
         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   // response payload is loaded on acceptance and then held until the host takes it
   always_ff @(posedge clk_i)
   begin
      if (wr_req)
         bresp_q <= wr_err_i ? RESP_SLVERR : RESP_OKAY;
      if (rd_req)
      begin
         rdata_q <= rd_data_i;
         rresp_q <= rd_err_i ? RESP_SLVERR : RESP_OKAY;
      end
   end

   assign reg_bvalid_o = (state_q == WRITE_RESP);
   assign reg_rvalid_o = (state_q == READ_RESP);
   assign reg_bresp_o  = bresp_q;
   assign reg_rresp_o  = rresp_q;
   assign reg_rdata_o  = rdata_q;

endmodule

/* src/zb_addr_pkg.sv */
package zb_addr_pkg;

   // the host window port drops the top two address bits
   localparam int HOST_ADDR_W     = 30;
   localparam int CORE_ADDR_W     = 32;

   // bit 29 picks between the DRAM window and the local window
   localparam int HOST_WINDOW_BIT = 29;
   localparam int HOST_OFFSET_W   = 28;

   // core DRAM starts here, the xor strips it before rebasing
   localparam logic [CORE_ADDR_W-1:0] DRAM_BASE_XOR = 32'h8000_0000;

   // profiler splits the DRAM space into 8 MB regions
   localparam int PROF_REGIONS    = 128;
   localparam int PROF_REGION_LSB = 23;

   // a core DRAM address, seen flat for translation or split for the profiler
   typedef union packed {
      logic [CORE_ADDR_W-1:0] raw;
      struct packed {
         logic [CORE_ADDR_W-$clog2(PROF_REGIONS)-PROF_REGION_LSB-1:0] top;
         logic [$clog2(PROF_REGIONS)-1:0]                             region;
         logic [PROF_REGION_LSB-1:0]                                  offset;
      } fields;
   } dram_addr_u;

endpackage

/* src/zb_regmap_pkg.sv */
package zb_regmap_pkg;

   // host register port, byte addressed
   localparam int REG_ADDR_W = 9;
   localparam int REG_DATA_W = 32;

   // read/write control registers
   localparam logic [REG_ADDR_W-1:0] REG_CTRL       = 9'h000;
   localparam logic [REG_ADDR_W-1:0] REG_DRAM_VALID = 9'h004;
   localparam logic [REG_ADDR_W-1:0] REG_DRAM_BASE  = 9'h008;

   // profiler bitmap, word n covers regions 32n up to 32n+31
   localparam logic [REG_ADDR_W-1:0] REG_PROF0      = 9'h00C;
   localparam logic [REG_ADDR_W-1:0] REG_PROF1      = 9'h010;
   localparam logic [REG_ADDR_W-1:0] REG_PROF2      = 9'h014;
   localparam logic [REG_ADDR_W-1:0] REG_PROF3      = 9'h018;

   // event counters, all read only
   localparam logic [REG_ADDR_W-1:0] REG_MCYCLE_LO   = 9'h01C;
   localparam logic [REG_ADDR_W-1:0] REG_MCYCLE_HI   = 9'h020;
   localparam logic [REG_ADDR_W-1:0] REG_DRAM_WR_CNT = 9'h024;
   localparam logic [REG_ADDR_W-1:0] REG_DRAM_RD_CNT = 9'h028;

   // AXI-lite response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
